// ==== dm_req_split.f ====
dm_split_pkg.sv
dm_req_intake.sv
dm_req_splitter.sv
dm_req_out_skid.sv
dm_req_split_top.sv
tb_dm_req_split.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DMA request splitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_dm_req_split

verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_dm_req_split -f dm_req_split.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "Failures reported, see $LOG"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "Simulation ended without a verdict, see $LOG"
    exit 1
fi

exit 0

// ==== tb_dm_req_split.sv ====
// DMA request splitter testbench
`default_nettype none

module tb_dm_req_split import dm_split_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // One expected output piece, plus what is needed to check its request as a whole
    typedef struct packed {
        dm_op_e           op;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [TAG_W-1:0]  tag;
        logic              fin;
        logic              sup;
        logic              last;
        logic [LEN_W-1:0]  orig_len;
    } piece_t;

    localparam int N_RAND = 200;

    logic clk;
    logic rst_n;
    logic i_req_valid;
    logic o_req_ready;
    dm_op_e i_req_op;
    logic [ADDR_W-1:0] i_req_addr;
    logic [LEN_W-1:0] i_req_len;
    logic [TAG_W-1:0] i_req_tag;
    logic o_pc_valid;
    logic i_pc_ready;
    dm_op_e o_pc_op;
    logic [ADDR_W-1:0] o_pc_addr;
    logic [LEN_W-1:0] o_pc_len;
    logic [TAG_W-1:0] o_pc_tag;
    logic o_pc_final_cpl;
    logic o_pc_suppress_commit;

    // Scoreboard state
    piece_t exp_q[$];
    piece_t exp_front;
    logic exp_valid = 1'b0;
    logic xfer_seen;
    logic req_taken;
    logic [LEN_W-1:0] obs_len;
    logic [LEN_W-1:0] acc_len = '0;
    logic [31:0] lfsr_state = 32'h51ded672;
    logic rand_ready_en = 1'b0;
    int err_count = 0;
    int pass_tests = 0;
    int fail_tests = 0;
    int total_pieces = 0;
    int cycles = 0;

    // Random requests, drawn before the run starts
    dm_op_e rnd_op[N_RAND];
    logic [ADDR_W-1:0] rnd_addr[N_RAND];
    logic [LEN_W-1:0] rnd_len[N_RAND];
    logic [TAG_W-1:0] rnd_tag[N_RAND];

    dm_req_split_top u_dut (
        .clk(clk), .rst_n(rst_n),
        .i_req_valid(i_req_valid), .o_req_ready(o_req_ready), .i_req_op(i_req_op),
        .i_req_addr(i_req_addr), .i_req_len(i_req_len), .i_req_tag(i_req_tag),
        .o_pc_valid(o_pc_valid), .i_pc_ready(i_pc_ready), .o_pc_op(o_pc_op),
        .o_pc_addr(o_pc_addr), .o_pc_len(o_pc_len), .o_pc_tag(o_pc_tag),
        .o_pc_final_cpl(o_pc_final_cpl), .o_pc_suppress_commit(o_pc_suppress_commit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ====================
    // Random source
    // ====================

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // Right-shifting Galois form, maximal length taps
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    // ====================
    // Reference model
    // ====================

    // Expands one request into the pieces the splitting rule asks for
    task automatic push_pieces(input dm_op_e op, input logic [ADDR_W-1:0] addr,
                               input logic [LEN_W-1:0] len, input logic [TAG_W-1:0] tag);
        piece_t p;
        logic [ADDR_W-1:0] cur;
        logic [LEN_W-1:0] rem;
        logic [LEN_W-1:0] room;
        logic [31:0] end_off;
        logic cut;
        end_off = 32'(addr % ADDR_W'(PAGE_BYTES)) + 32'(len);
        cut = (op == OP_MRD || op == OP_MWR) &&
              (len > LEN_W'(REQ_MAX_BYTES) || end_off > PAGE_BYTES);
        cur = addr;
        rem = len;
        p.op = op;
        p.tag = tag;
        p.orig_len = len;
        // An uncut request is one piece, even when its length is zero
        do begin
            room = cut ? LEN_W'(REQ_MAX_BYTES) - LEN_W'(cur % ADDR_W'(REQ_MAX_BYTES)) : rem;
            p.addr = cur;
            p.last = rem <= room;
            p.len = p.last ? rem : room;
            p.fin = (op == OP_MRD) && p.last;
            p.sup = (op == OP_MWR) && !p.last;
            exp_q.push_back(p);
            total_pieces++;
            cur = cur + ADDR_W'(p.len);
            rem = rem - p.len;
        end while (rem != 0);
    endtask

    // Handshakes seen on the rising edge, read back on the falling edge
    always @(posedge clk) begin
        xfer_seen <= rst_n && o_pc_valid && i_pc_ready;
        req_taken <= rst_n && i_req_valid && o_req_ready;
        obs_len <= o_pc_len;
    end

    // Retire the piece that just left and expose the next expected one
    always @(negedge clk) begin
        if (xfer_seen && exp_q.size() != 0) begin
            acc_len = acc_len + obs_len;
            if (exp_q[0].last) begin
                len_sum: assert (acc_len == exp_q[0].orig_len) else begin
                    $display("FAIL t=%0t piece length sum expected %0d got %0d",
                             $time, exp_q[0].orig_len, acc_len);
                    err_count++;
                end
                acc_len = '0;
            end
            void'(exp_q.pop_front());
        end
        exp_valid = exp_q.size() != 0;
        if (exp_valid) begin
            exp_front = exp_q[0];
        end
    end

    // ====================
    // Output checks
    // ====================

    piece_expected: assert property (@(posedge clk) disable iff (!rst_n)
        (o_pc_valid && i_pc_ready) |-> exp_valid) else begin
        $display("Unexpected extra piece on the output at %0t", $time);
        err_count++;
    end

    op_match: assert property (@(posedge clk) disable iff (!rst_n)
        (o_pc_valid && i_pc_ready && exp_valid) |-> o_pc_op == exp_front.op) else begin
        $display("FAIL t=%0t o_pc_op expected %0d got %0d", $time, exp_front.op, o_pc_op);
        err_count++;
    end

    addr_match: assert property (@(posedge clk) disable iff (!rst_n)
        (o_pc_valid && i_pc_ready && exp_valid) |-> o_pc_addr == exp_front.addr) else begin
        $display("FAIL t=%0t o_pc_addr expected %h got %h", $time, exp_front.addr, o_pc_addr);
        err_count++;
    end

    len_match: assert property (@(posedge clk) disable iff (!rst_n)
        (o_pc_valid && i_pc_ready && exp_valid) |-> o_pc_len == exp_front.len) else begin
        $display("FAIL t=%0t o_pc_len expected %0d got %0d", $time, exp_front.len, o_pc_len);
        err_count++;
    end

    tag_match: assert property (@(posedge clk) disable iff (!rst_n)
        (o_pc_valid && i_pc_ready && exp_valid) |-> o_pc_tag == exp_front.tag) else begin
        $display("FAIL t=%0t o_pc_tag expected %h got %h", $time, exp_front.tag, o_pc_tag);
        err_count++;
    end

    fin_match: assert property (@(posedge clk) disable iff (!rst_n)
        (o_pc_valid && i_pc_ready && exp_valid) |-> o_pc_final_cpl == exp_front.fin) else begin
        $display("FAIL t=%0t o_pc_final_cpl expected %b got %b",
                 $time, exp_front.fin, o_pc_final_cpl);
        err_count++;
    end

    sup_match: assert property (@(posedge clk) disable iff (!rst_n)
        (o_pc_valid && i_pc_ready && exp_valid) |-> o_pc_suppress_commit == exp_front.sup)
    else begin
        $display("FAIL t=%0t o_pc_suppress_commit expected %b got %b",
                 $time, exp_front.sup, o_pc_suppress_commit);
        err_count++;
    end

    // A stalled piece must stay put until it is taken
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (o_pc_valid && !i_pc_ready) |=> (o_pc_valid && $stable(o_pc_op) && $stable(o_pc_addr)
        && $stable(o_pc_len) && $stable(o_pc_tag) && $stable(o_pc_final_cpl)
        && $stable(o_pc_suppress_commit))) else begin
        $display("Stalled output piece changed or vanished at %0t", $time);
        err_count++;
    end

    // Cycle limit scales with the work queued so far
    always @(posedge clk) begin
        cycles++;
        if (cycles > total_pieces * 20 + 200) begin
            $display("Timeout after %0d cycles with %0d pieces still missing",
                     cycles, exp_q.size());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ====================
    // Stimulus
    // ====================

    // Output ready is random during the random test and high otherwise
    initial begin
        logic [63:0] r;
        i_pc_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (rand_ready_en) begin
                draw_bits(2, r);
                i_pc_ready = r[1:0] != 2'b00;
            end else begin
                i_pc_ready = 1'b1;
            end
        end
    end

    // Called on a falling edge, returns on the falling edge after acceptance
    task automatic send_req(input dm_op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [LEN_W-1:0] len, input logic [TAG_W-1:0] tag);
        i_req_valid = 1'b1;
        i_req_op = op;
        i_req_addr = addr;
        i_req_len = len;
        i_req_tag = tag;
        push_pieces(op, addr, len, tag);
        @(negedge clk);
        while (!req_taken) @(negedge clk);
        i_req_valid = 1'b0;
    endtask

    // Waits for all expected pieces, then reports the test
    task automatic finish_test(input string name, input int errs_before);
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("Test %s: passed", name);
        end else begin
            fail_tests++;
            $display("Test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    initial begin
        logic [63:0] r;
        int errs;
        i_req_valid = 1'b0;
        i_req_op = OP_MRD;
        i_req_addr = '0;
        i_req_len = '0;
        i_req_tag = '0;
        rst_n = 1'b0;

        // Lengths stay under 1 KB so a request gives at most a few dozen pieces
        for (int i = 0; i < N_RAND; i++) begin
            draw_bits(2, r);
            rnd_op[i] = (r[1:0] == 2'd1) ? OP_MWR : (r[1:0] == 2'd2) ? OP_OTHER : OP_MRD;
            draw_bits(64, r);
            rnd_addr[i] = r;
            draw_bits(10, r);
            rnd_len[i] = LEN_W'(r[9:0]);
            draw_bits(8, r);
            rnd_tag[i] = r[TAG_W-1:0];
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_state: assert (!o_pc_valid && o_req_ready) else begin
            $display("Output valid or input ready wrong right after reset");
            err_count++;
        end

        errs = err_count;
        send_req(OP_MRD, 64'h0000_1234_0000_0100, 24'd32, 8'h11);
        finish_test("short read", errs);

        errs = err_count;
        send_req(OP_MRD, 64'h0000_0000_0004_0000, 24'd256, 8'h22);
        finish_test("aligned 256 byte read", errs);

        errs = err_count;
        send_req(OP_MRD, 64'h0000_0000_0000_0FF0, 24'd32, 8'h33);
        send_req(OP_MRD, 64'h0000_0008_0000_0028, 24'd200, 8'h34);
        finish_test("unaligned reads", errs);

        errs = err_count;
        send_req(OP_MWR, 64'h0000_0000_0000_2010, 24'd150, 8'h44);
        finish_test("split write", errs);

        errs = err_count;
        send_req(OP_OTHER, 64'h0000_0000_0000_0FF0, 24'd300, 8'h55);
        send_req(OP_MRD, 64'h0000_0000_0000_0040, 24'd0, 8'h56);
        finish_test("pass through", errs);

        errs = err_count;
        rand_ready_en = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            send_req(rnd_op[i], rnd_addr[i], rnd_len[i], rnd_tag[i]);
        end
        while (exp_q.size() != 0) @(negedge clk);
        rand_ready_en = 1'b0;
        finish_test("random traffic", errs);

        $display("Tests passed %0d, failed %0d, check errors %0d",
                 pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dm_req_split_top.sv ====
// DMA request splitter top
`default_nettype none

module dm_req_split_top import dm_split_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,

    // Host-side requests in
    input  wire               i_req_valid,
    output logic              o_req_ready,
    input  dm_op_e            i_req_op,
    input  wire [ADDR_W-1:0]  i_req_addr,
    input  wire [LEN_W-1:0]   i_req_len,
    input  wire [TAG_W-1:0]   i_req_tag,

    // Split pieces out
    output logic              o_pc_valid,
    input  wire               i_pc_ready,
    output dm_op_e            o_pc_op,
    output logic [ADDR_W-1:0] o_pc_addr,
    output logic [LEN_W-1:0]  o_pc_len,
    output logic [TAG_W-1:0]  o_pc_tag,
    output logic              o_pc_final_cpl,
    output logic              o_pc_suppress_commit
);

    // ====================
    // Intake to splitter
    // ====================

    logic                 s_valid;
    logic                 s_ready;
    dm_op_e               s_op;
    logic [ADDR_W-1:0]    s_addr;
    logic [LEN_W-1:0]     s_len;
    logic [TAG_W-1:0]     s_tag;
    logic                 s_needs_split;
    logic [PAGE_LOG2-1:0] s_page_off;

    // ====================
    // Splitter to skid
    // ====================

    logic                 p_valid;
    logic                 p_ready;
    dm_op_e               p_op;
    logic [ADDR_W-1:0]    p_addr;
    logic [LEN_W-1:0]     p_len;
    logic [TAG_W-1:0]     p_tag;
    logic                 p_final_cpl;
    logic                 p_suppress_commit;

    // Decode and register each request as it arrives
    dm_req_intake u_intake (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_valid       (i_req_valid),
        .o_ready       (o_req_ready),
        .i_op          (i_req_op),
        .i_addr        (i_req_addr),
        .i_len         (i_req_len),
        .i_tag         (i_req_tag),
        .o_valid       (s_valid),
        .i_ready       (s_ready),
        .o_op          (s_op),
        .o_addr        (s_addr),
        .o_len         (s_len),
        .o_tag         (s_tag),
        .o_needs_split (s_needs_split),
        .o_page_off    (s_page_off)
    );

    // Cut each request into window-sized pieces
    dm_req_splitter u_splitter (
        .clk               (clk),
        .rst_n             (rst_n),
        .i_valid           (s_valid),
        .o_ready           (s_ready),
        .i_op              (s_op),
        .i_addr            (s_addr),
        .i_len             (s_len),
        .i_tag             (s_tag),
        .i_needs_split     (s_needs_split),
        .i_page_off        (s_page_off),
        .o_valid           (p_valid),
        .i_ready           (p_ready),
        .o_op              (p_op),
        .o_addr            (p_addr),
        .o_len             (p_len),
        .o_tag             (p_tag),
        .o_final_cpl       (p_final_cpl),
        .o_suppress_commit (p_suppress_commit)
    );

    // Register the pieces so the outputs come from flops
    dm_req_out_skid u_out_skid (
        .clk               (clk),
        .rst_n             (rst_n),
        .i_valid           (p_valid),
        .o_ready           (p_ready),
        .i_op              (p_op),
        .i_addr            (p_addr),
        .i_len             (p_len),
        .i_tag             (p_tag),
        .i_final_cpl       (p_final_cpl),
        .i_suppress_commit (p_suppress_commit),
        .o_valid           (o_pc_valid),
        .i_ready           (i_pc_ready),
        .o_op              (o_pc_op),
        .o_addr            (o_pc_addr),
        .o_len             (o_pc_len),
        .o_tag             (o_pc_tag),
        .o_final_cpl       (o_pc_final_cpl),
        .o_suppress_commit (o_pc_suppress_commit)
    );

endmodule

`default_nettype wire

// ==== dm_req_out_skid.sv ====
// Piece output skid buffer
`default_nettype none

module dm_req_out_skid import dm_split_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,

    // Pieces from the splitter
    input  wire               i_valid,
    output logic              o_ready,
    input  dm_op_e            i_op,
    input  wire [ADDR_W-1:0]  i_addr,
    input  wire [LEN_W-1:0]   i_len,
    input  wire [TAG_W-1:0]   i_tag,
    input  wire               i_final_cpl,
    input  wire               i_suppress_commit,

    // Registered pieces to the host side
    output logic              o_valid,
    input  wire               i_ready,
    output dm_op_e            o_op,
    output logic [ADDR_W-1:0] o_addr,
    output logic [LEN_W-1:0]  o_len,
    output logic [TAG_W-1:0]  o_tag,
    output logic              o_final_cpl,
    output logic              o_suppress_commit
);

    // ====================
    // Storage
    // ====================

    // Main entry feeds the outputs directly
    logic              main_valid;

    // Spare entry catches the piece that arrives while main is stalled
    logic              spare_valid;
    dm_op_e            spare_op;
    logic [ADDR_W-1:0] spare_addr;
    logic [LEN_W-1:0]  spare_len;
    logic [TAG_W-1:0]  spare_tag;
    logic              spare_final_cpl;
    logic              spare_suppress_commit;

    logic              in_xfer;
    logic              main_free;

    // Ready only reflects whether the spare slot is free
    assign o_ready   = !spare_valid;
    assign in_xfer   = i_valid && !spare_valid;

    // Main can take a new piece when empty or being drained this cycle
    assign main_free = !main_valid || i_ready;

    assign o_valid   = main_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            main_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else if (main_free) begin
            // Spare always drains first to keep pieces in order
            main_valid  <= spare_valid || in_xfer;
            spare_valid <= 1'b0;
        end else if (in_xfer) begin
            spare_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_free) begin
            if (spare_valid) begin
                o_op              <= spare_op;
                o_addr            <= spare_addr;
                o_len             <= spare_len;
                o_tag             <= spare_tag;
                o_final_cpl       <= spare_final_cpl;
                o_suppress_commit <= spare_suppress_commit;
            end else if (in_xfer) begin
                o_op              <= i_op;
                o_addr            <= i_addr;
                o_len             <= i_len;
                o_tag             <= i_tag;
                o_final_cpl       <= i_final_cpl;
                o_suppress_commit <= i_suppress_commit;
            end
        end else if (in_xfer) begin
            spare_op              <= i_op;
            spare_addr            <= i_addr;
            spare_len             <= i_len;
            spare_tag             <= i_tag;
            spare_final_cpl       <= i_final_cpl;
            spare_suppress_commit <= i_suppress_commit;
        end
    end

endmodule

`default_nettype wire

// ==== dm_req_splitter.sv ====
// Request splitter stage
`default_nettype none

module dm_req_splitter import dm_split_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,

    // Decoded request from the intake register
    input  wire                  i_valid,
    output logic                 o_ready,
    input  dm_op_e               i_op,
    input  wire [ADDR_W-1:0]     i_addr,
    input  wire [LEN_W-1:0]      i_len,
    input  wire [TAG_W-1:0]      i_tag,
    input  wire                  i_needs_split,
    input  wire [PAGE_LOG2-1:0]  i_page_off,

    // One piece per accepted cycle toward the output skid
    output logic                 o_valid,
    input  wire                  i_ready,
    output dm_op_e               o_op,
    output logic [ADDR_W-1:0]    o_addr,
    output logic [LEN_W-1:0]     o_len,
    output logic [TAG_W-1:0]     o_tag,
    output logic                 o_final_cpl,
    output logic                 o_suppress_commit
);

    // ====================
    // Holding register
    // ====================

    // A request is being worked on
    logic                    busy;

    // The next piece is the first one of its request
    logic                    first_q;

    // Request was marked for cutting at intake
    logic                    split_q;

    dm_op_e                  op_q;
    logic [TAG_W-1:0]        tag_q;

    // Start address of the next piece
    logic [ADDR_W-1:0]       addr_q;

    // Bytes not yet covered by an issued piece
    logic [LEN_W-1:0]        rem_q;

    // Start offset inside the first REQ_MAX_BYTES window
    logic [REQ_MAX_LOG2-1:0] win_off_q;

    // ====================
    // Next piece
    // ====================

    logic [LEN_W-1:0]        win_off_ext;
    logic [LEN_W-1:0]        piece_len;
    logic [ADDR_W-1:0]       addr_step;
    logic                    piece_last;
    logic                    xfer_out;
    logic                    done;
    logic                    load;

    assign win_off_ext = {{(LEN_W - REQ_MAX_LOG2){1'b0}}, win_off_q};

    always_comb begin
        // Unsplit requests go out whole, and are always the last piece
        piece_last = 1'b1;
        piece_len  = rem_q;

        if (split_q) begin
            if (first_q) begin
                // First piece runs up to the next window boundary
                // A request that needed cutting always reaches past that boundary,
                // because a page boundary is also a window boundary
                piece_last = 1'b0;
                piece_len  = LEN_W'(REQ_MAX_BYTES) - win_off_ext;
            end else begin
                // Address is window aligned from here on
                piece_last = rem_q <= LEN_W'(REQ_MAX_BYTES);
                piece_len  = piece_last ? rem_q : LEN_W'(REQ_MAX_BYTES);
            end
        end
    end

    assign addr_step = {{(ADDR_W - LEN_W){1'b0}}, piece_len};

    // Piece fields are straight from the holding register
    assign o_valid           = busy;
    assign o_op              = op_q;
    assign o_addr            = addr_q;
    assign o_len             = piece_len;
    assign o_tag             = tag_q;

    // Reads flag the piece carrying the final completion
    assign o_final_cpl       = (op_q == OP_MRD) && piece_last;

    // Writes hold back the commit message until the last piece
    assign o_suppress_commit = (op_q == OP_MWR) && !piece_last;

    // ====================
    // Handshake
    // ====================

    assign xfer_out = busy && i_ready;
    assign done     = xfer_out && piece_last;

    // Next request is taken while idle, or as the last piece leaves,
    // so back-to-back requests run without a bubble
    assign o_ready  = !busy || done;
    assign load     = i_valid && o_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            first_q <= 1'b0;
        end else if (load) begin
            busy    <= 1'b1;
            first_q <= 1'b1;
        end else if (xfer_out) begin
            first_q <= 1'b0;
            if (piece_last) begin
                busy <= 1'b0;
            end
        end
    end

    // Request payload and the running address and length
    always_ff @(posedge clk) begin
        if (load) begin
            op_q      <= i_op;
            tag_q     <= i_tag;
            addr_q    <= i_addr;
            rem_q     <= i_len;
            split_q   <= i_needs_split;
            win_off_q <= i_page_off[REQ_MAX_LOG2-1:0];
        end else if (xfer_out) begin
            // Move past the piece just sent
            addr_q <= addr_q + addr_step;
            rem_q  <= rem_q - piece_len;
        end
    end

endmodule

`default_nettype wire

// ==== dm_req_intake.sv ====
// Request intake register
`default_nettype none

module dm_req_intake import dm_split_pkg::*; (
    input  wire                  clk,
    input  wire                  rst_n,

    // Incoming request header
    input  wire                  i_valid,
    output logic                 o_ready,
    input  dm_op_e               i_op,
    input  wire [ADDR_W-1:0]     i_addr,
    input  wire [LEN_W-1:0]      i_len,
    input  wire [TAG_W-1:0]      i_tag,

    // Registered request toward the splitter
    output logic                 o_valid,
    input  wire                  i_ready,
    output dm_op_e               o_op,
    output logic [ADDR_W-1:0]    o_addr,
    output logic [LEN_W-1:0]     o_len,
    output logic [TAG_W-1:0]     o_tag,
    output logic                 o_needs_split,
    output logic [PAGE_LOG2-1:0] o_page_off
);

    // ====================
    // Split decision
    // ====================

    logic                 is_mem_req;
    logic [PAGE_LOG2-1:0] page_off;
    logic [LEN_W:0]       end_off;
    logic                 too_long;
    logic                 crosses_page;
    logic                 needs_split;
    logic                 load;

    // Start offset within the 4 KB page
    assign page_off = i_addr[PAGE_LOG2-1:0];

    // One spare bit on top so that the end offset cannot wrap
    assign end_off = {1'b0, {(LEN_W - PAGE_LOG2){1'b0}}, page_off} + {1'b0, i_len};

    assign is_mem_req   = (i_op == OP_MRD) || (i_op == OP_MWR);
    assign too_long     = i_len > LEN_W'(REQ_MAX_BYTES);
    assign crosses_page = end_off > (LEN_W + 1)'(PAGE_BYTES);

    // Zero-length and short in-page requests fall out of both compares
    assign needs_split = is_mem_req && (too_long || crosses_page);

    // ====================
    // Pipeline register
    // ====================

    // Accept when empty or when the held request leaves in this same cycle
    assign o_ready = !o_valid || i_ready;
    assign load    = i_valid && o_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
        end else if (load) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    // Payload is only looked at while o_valid is high
    always_ff @(posedge clk) begin
        if (load) begin
            o_op          <= i_op;
            o_addr        <= i_addr;
            o_len         <= i_len;
            o_tag         <= i_tag;
            o_needs_split <= needs_split;
            o_page_off    <= page_off;
        end
    end

endmodule

`default_nettype wire

// ==== dm_split_pkg.sv ====
// DMA request splitter definitions
`default_nettype none

package dm_split_pkg;

    // ====================
    // Request opcodes
    // ====================

    // Only reads and write headers are ever cut into pieces
    // Everything else is forwarded as a single final piece
    typedef enum logic [1:0] {
        OP_MRD   = 2'd0,
        OP_MWR   = 2'd1,
        OP_OTHER = 2'd2
    } dm_op_e;

    // ====================
    // Field widths
    // ====================

    // Host byte address
    localparam int unsigned ADDR_W = 64;

    // Request length in bytes
    localparam int unsigned LEN_W = 24;

    // Request tag, copied unchanged onto every piece
    localparam int unsigned TAG_W = 8;

    // ====================
    // Split geometry
    // ====================

    // Largest piece the splitter may emit
    // Must be a power of two and no larger than a page, so that full pieces
    // tile each page exactly and never straddle a page boundary
    localparam int unsigned REQ_MAX_BYTES = 64;

    // Number of address bits covered by one REQ_MAX_BYTES window
    localparam int unsigned REQ_MAX_LOG2 = 6;

    // Pieces must never cross a boundary of this size
    localparam int unsigned PAGE_BYTES = 4096;

    // Width of the byte offset within one page
    localparam int unsigned PAGE_LOG2 = 12;

    // Both sizes must agree with their log2 values, and the window must fit in a page.
    // The offset within a window is taken as the low bits of the page offset,
    // which only works while REQ_MAX_LOG2 does not exceed PAGE_LOG2.
    // The page offset is also widened to LEN_W bits in the split compare,
    // so PAGE_LOG2 must stay below LEN_W

endpackage

`default_nettype wire
